//--- source/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////
    // Fetch address and prediction types
    //////////////////////////////////////////////////

    // Byte address of one instruction word
    typedef logic [31:0] pc_t;

    // Branch kind of a fetch slot
    typedef enum logic [1:0] {
        BR_NONE     = 2'd0,
        BR_COND     = 2'd1,
        BR_DIRECT   = 2'd2,
        BR_INDIRECT = 2'd3
    } brtype_e;

    // Per-slot prediction, kind on top and target below
    typedef struct packed {
        brtype_e brtype;
        pc_t     target;
    } pred_t;

    //////////////////////////////////////////////////
    // Fetch constants and BTB sizing
    //////////////////////////////////////////////////

    localparam pc_t RESET_PC   = 32'h1C00_0000;
    localparam pc_t FETCH_STEP = 32'd8;

    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;
    // Word offset bits and index bits sit below the tag
    localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;

endpackage

//--- source/inst_pkg.sv
package inst_pkg;

    //////////////////////////////////////////////////
    // Branch opcodes, bits 31:26
    //////////////////////////////////////////////////

    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;
    localparam logic [5:0] OP_BEQ  = 6'b010110;
    localparam logic [5:0] OP_BNE  = 6'b010111;
    localparam logic [5:0] OP_BLT  = 6'b011000;
    localparam logic [5:0] OP_BGE  = 6'b011001;
    localparam logic [5:0] OP_BLTU = 6'b011010;
    localparam logic [5:0] OP_BGEU = 6'b011011;

    // andi r0, r0, 0
    localparam logic [31:0] NOP_WORD = 32'h0340_0000;

    //////////////////////////////////////////////////
    // One instruction word, two decodings
    //////////////////////////////////////////////////

    typedef union packed {
        // B and BL, offset split with the high part at the bottom
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } b26;
        // Conditional branches and JIRL
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } b16;
    } inst_u;

endpackage

//--- source/fetch_if.sv
`timescale 1ns/1ps

// One fetch pair with its predictions
interface fetch_pair_if;
    import fetch_pkg::*;

    pc_t   pc1;
    pc_t   pc2;
    pred_t pred1;
    pred_t pred2;
    logic  valid;

    modport src (output pc1, pc2, pred1, pred2, valid);
    modport dst (input  pc1, pc2, pred1, pred2, valid);
endinterface

// BTB training port, written at the clock edge when we is high
interface btb_update_if;
    import fetch_pkg::*;

    logic  we;
    pc_t   pc;
    pred_t pred;

    modport master (output we, pc, pred);
    modport slave  (input  we, pc, pred);
endinterface

//--- source/btb_predictor.sv
`timescale 1ns/1ps

module btb_predictor (
    input  logic             clk,
    input  logic             rstn,
    input  fetch_pkg::pc_t   i_pc,
    btb_update_if.slave      upd,
    output fetch_pkg::pred_t o_pred1,
    output fetch_pkg::pred_t o_pred2
);
    import fetch_pkg::*;

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [BTB_TAG_W-1:0]   tag_mem  [BTB_ENTRIES];
    pred_t                  pred_mem [BTB_ENTRIES];
    logic [BTB_IDX_W-1:0]   upd_idx;
    pc_t                    pc2;

    // Miss or stale entry falls through
    function automatic pred_t lookup(input pc_t pc);
        logic [BTB_IDX_W-1:0] idx;
        pred_t                res;
        idx = pc[BTB_IDX_W+1:2];
        res = pred_mem[idx];
        if (!valid_q[idx] || tag_mem[idx] != pc[31:BTB_IDX_W+2]) begin
            res.brtype = BR_NONE;
        end
        return res;
    endfunction

    assign pc2     = i_pc + 32'd4;
    assign upd_idx = upd.pc[BTB_IDX_W+1:2];

    // Both slots looked up in the same cycle
    always_comb begin
        o_pred1 = lookup(i_pc);
        o_pred2 = lookup(pc2);
    end

    // BR_NONE on update drops the entry
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (upd.we) begin
            valid_q[upd_idx] <= (upd.pred.brtype != BR_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (upd.we) begin
            tag_mem[upd_idx]  <= upd.pc[31:BTB_IDX_W+2];
            pred_mem[upd_idx] <= upd.pred;
        end
    end

endmodule

//--- source/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic           clk,
    input  logic           rstn,
    input  logic           i_stall,
    input  logic           i_flush,
    input  fetch_pkg::pc_t i_flush_pc,
    input  logic           i_redirect,
    input  fetch_pkg::pc_t i_redirect_pc,
    btb_update_if.slave    upd,
    fetch_pair_if.src      o_pair,
    output fetch_pkg::pc_t o_fetch_pc
);
    import fetch_pkg::*;

    pc_t   pc_q;
    pc_t   pc_d;
    logic  valid_q;
    pred_t pred1;
    pred_t pred2;

    btb_predictor u_btb (
        .clk     (clk),
        .rstn    (rstn),
        .i_pc    (pc_q),
        .upd     (upd),
        .o_pred1 (pred1),
        .o_pred2 (pred2)
    );

    //////////////////////////////////////////////////
    // Next PC selection
    //////////////////////////////////////////////////

    always_comb begin
        if (i_flush) begin
            pc_d = i_flush_pc;
        end else if (i_redirect) begin
            pc_d = i_redirect_pc;
        end else if (i_stall || !valid_q) begin
            // Start-up cycle also keeps RESET_PC
            pc_d = pc_q;
        end else if (pred1.brtype != BR_NONE) begin
            pc_d = pred1.target;
        end else if (pred2.brtype != BR_NONE) begin
            pc_d = pred2.target;
        end else begin
            pc_d = pc_q + FETCH_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_d;
            valid_q <= 1'b1;
        end
    end

    assign o_fetch_pc   = pc_q;
    assign o_pair.pc1   = pc_q;
    assign o_pair.pc2   = pc_q + 32'd4;
    assign o_pair.pred1 = pred1;
    assign o_pair.pred2 = pred2;
    assign o_pair.valid = valid_q;

    // Flush, redirect and BTB targets all keep word alignment
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rstn)
        pc_q[1:0] == 2'b00);

endmodule

//--- source/if1_if2_reg.sv
`timescale 1ns/1ps

module if1_if2_reg (
    input  logic      clk,
    input  logic      rstn,
    input  logic      i_stall,
    input  logic      i_flush_br,
    input  logic      i_redirect,
    fetch_pair_if.dst i_pair,
    fetch_pair_if.src o_pair
);

    logic flush;
    logic valid_q;

    // Redirect drops the IF1 pair, the IF2 pair that raised it stays visible
    assign flush = i_flush_br | i_redirect;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (!i_stall) begin
            valid_q <= i_pair.valid;
        end
    end

    assign o_pair.valid = valid_q & ~i_flush_br & ~i_stall;

    //////////////////////////////////////////////////
    // Payload, frozen while the cache stalls
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_pair.pc1   <= i_pair.pc1;
            o_pair.pc2   <= i_pair.pc2;
            o_pair.pred1 <= i_pair.pred1;
            o_pair.pred2 <= i_pair.pred2;
        end
    end

    // Redirect only comes from a pair shown in IF2
    a_redirect_visible: assert property (@(posedge clk) disable iff (!rstn)
        i_redirect |-> o_pair.valid);

endmodule

//--- source/predecoder.sv
`timescale 1ns/1ps

module predecoder (
    fetch_pair_if.dst        i_pair,
    input  inst_pkg::inst_u  i_inst1,
    input  inst_pkg::inst_u  i_inst2,
    output logic [1:0]       o_slot_valid,
    output logic             o_redirect,
    output fetch_pkg::pc_t   o_redirect_pc,
    btb_update_if.master     o_upd
);
    import fetch_pkg::*;
    import inst_pkg::*;

    logic  taken1;
    logic  fix1;
    logic  fix2;
    logic  slot2_live;
    pc_t   fix_pc1;
    pc_t   fix_pc2;
    pred_t fix_pred1;
    pred_t fix_pred2;

    // Checks one slot against its prediction
    function automatic void check_slot(
        input  pc_t   pc,
        input  pred_t pred,
        input  inst_u inst,
        output logic  fix,
        output pc_t   fix_pc,
        output pred_t fix_pred
    );
        logic [25:0] offs26;
        pc_t         tgt26;
        pc_t         tgt16;
        logic        taken;
        offs26 = {inst.b26.offs_hi, inst.b26.offs_lo};
        tgt26  = pc + {{4{offs26[25]}}, offs26, 2'b00};
        tgt16  = pc + {{14{inst.b16.offs[15]}}, inst.b16.offs, 2'b00};
        taken  = (pred.brtype != BR_NONE);

        fix             = 1'b0;
        fix_pc          = pc + 32'd4;
        fix_pred.brtype = BR_NONE;
        fix_pred.target = '0;
        case (inst.b26.opcode)
            OP_B, OP_BL: begin
                if (pred.brtype != BR_DIRECT || pred.target != tgt26) begin
                    fix             = 1'b1;
                    fix_pc          = tgt26;
                    fix_pred.brtype = BR_DIRECT;
                    fix_pred.target = tgt26;
                end
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                fix = taken && (pred.target != tgt16);
            end
            // Indirect target unknown here
            OP_JIRL: fix = 1'b0;
            default: fix = taken;
        endcase
    endfunction

    always_comb begin
        check_slot(i_pair.pc1, i_pair.pred1, i_inst1, fix1, fix_pc1, fix_pred1);
        check_slot(i_pair.pc2, i_pair.pred2, i_inst2, fix2, fix_pc2, fix_pred2);

        // Slot 2 dies behind a taken or corrected slot 1
        taken1       = (i_pair.pred1.brtype != BR_NONE);
        slot2_live   = i_pair.valid & ~taken1 & ~fix1;
        o_slot_valid = {slot2_live, i_pair.valid};

        if (i_pair.valid && fix1) begin
            o_redirect    = 1'b1;
            o_redirect_pc = fix_pc1;
            o_upd.pc      = i_pair.pc1;
            o_upd.pred    = fix_pred1;
        end else if (slot2_live && fix2) begin
            o_redirect    = 1'b1;
            o_redirect_pc = fix_pc2;
            o_upd.pc      = i_pair.pc2;
            o_upd.pred    = fix_pred2;
        end else begin
            o_redirect    = 1'b0;
            o_redirect_pc = fix_pc1;
            o_upd.pc      = i_pair.pc1;
            o_upd.pred    = fix_pred1;
        end
        o_upd.we = o_redirect;
    end

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic           clk,
    input  logic           rstn,
    input  logic           i_stall_icache,
    input  logic           i_flush_br,
    input  fetch_pkg::pc_t i_flush_pc,
    input  logic [31:0]    i_inst1,
    input  logic [31:0]    i_inst2,
    output fetch_pkg::pc_t o_fetch_pc,
    output fetch_pkg::pc_t o_pc1,
    output fetch_pkg::pc_t o_pc2,
    output logic [1:0]     o_valid,
    output logic           o_redirect,
    output fetch_pkg::pc_t o_redirect_pc
);

    fetch_pair_if if1_pair ();
    fetch_pair_if if2_pair ();
    btb_update_if btb_upd ();

    //////////////////////////////////////////////////
    // IF1
    //////////////////////////////////////////////////

    pc_gen u_pc_gen (
        .clk           (clk),
        .rstn          (rstn),
        .i_stall       (i_stall_icache),
        .i_flush       (i_flush_br),
        .i_flush_pc    (i_flush_pc),
        .i_redirect    (o_redirect),
        .i_redirect_pc (o_redirect_pc),
        .upd           (btb_upd),
        .o_pair        (if1_pair),
        .o_fetch_pc    (o_fetch_pc)
    );

    if1_if2_reg u_if1_if2 (
        .clk        (clk),
        .rstn       (rstn),
        .i_stall    (i_stall_icache),
        .i_flush_br (i_flush_br),
        .i_redirect (o_redirect),
        .i_pair     (if1_pair),
        .o_pair     (if2_pair)
    );

    //////////////////////////////////////////////////
    // IF2
    //////////////////////////////////////////////////

    predecoder u_predecoder (
        .i_pair        (if2_pair),
        .i_inst1       (i_inst1),
        .i_inst2       (i_inst2),
        .o_slot_valid  (o_valid),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_upd         (btb_upd)
    );

    assign o_pc1 = if2_pair.pc1;
    assign o_pc2 = if2_pair.pc2;

endmodule

//--- tb/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;
    import inst_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int PAIR_CYCLES  = 20;
    localparam DATA_FILE = "tb/fetch_testdata.txt";

    // One S or E record of the test data
    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] cycles;
        logic        stall;
        logic        flush;
        pc_t         flush_pc;
        pc_t         pc1;
        logic [1:0]  valid;
        logic        redirect;
        pc_t         redirect_pc;
    } step_t;

    logic        clk = 1'b0;
    logic        rstn;
    logic        i_stall_icache;
    logic        i_flush_br;
    pc_t         i_flush_pc;
    logic [31:0] i_inst1;
    logic [31:0] i_inst2;
    pc_t         o_fetch_pc;
    pc_t         o_pc1;
    pc_t         o_pc2;
    logic [1:0]  o_valid;
    logic        o_redirect;
    pc_t         o_redirect_pc;

    logic [31:0] mem [pc_t];
    step_t       steps [$];
    int          cycle_count = 0;
    int          cycle_limit = RESET_CYCLES;
    pc_t         cache_pc;
    logic        cache_stall;
    // Fetch PC whose words the cache returned last
    pc_t         latched_pc;

    fetch_top i_fetch_top (
        .clk            (clk),
        .rstn           (rstn),
        .i_stall_icache (i_stall_icache),
        .i_flush_br     (i_flush_br),
        .i_flush_pc     (i_flush_pc),
        .i_inst1        (i_inst1),
        .i_inst2        (i_inst2),
        .o_fetch_pc     (o_fetch_pc),
        .o_pc1          (o_pc1),
        .o_pc2          (o_pc2),
        .o_valid        (o_valid),
        .o_redirect     (o_redirect),
        .o_redirect_pc  (o_redirect_pc)
    );

    always #20 clk = ~clk;

    task automatic end_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        if (actual !== expected) begin
            end_with_failure($sformatf("Error at %0t: %s expected %h, got %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic check_valid(input logic [1:0] expected, input logic [1:0] actual);
        if (actual !== expected) begin
            end_with_failure($sformatf("Error at %0t: o_valid expected %b, got %b",
                $time, expected, actual));
        end
    endtask

    // Redirect PC only means something with the flag up
    task automatic check_redirect(input logic exp_flag, input pc_t exp_pc,
                                  input logic act_flag, input pc_t act_pc);
        if (act_flag !== exp_flag) begin
            end_with_failure($sformatf("Error at %0t: o_redirect expected %b, got %b",
                $time, exp_flag, act_flag));
        end else if (exp_flag && act_pc !== exp_pc) begin
            end_with_failure($sformatf("Error at %0t: o_redirect_pc expected %h, got %h",
                $time, exp_pc, act_pc));
        end
    endtask

    //////////////////////////////////////////////////
    // Test data reader
    //////////////////////////////////////////////////

    task automatic load_testdata();
        int          fd;
        int          count;
        string       line;
        string       fields;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        step_t       s;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            end_with_failure("Could not open the test data file tb/fetch_testdata.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = line.substr(1, line.len() - 1);
            s      = '0;
            s.kind = line.getc(0);
            case (s.kind)
                "M": begin
                    count = $sscanf(fields, "%h %h", a, b);
                    mem[a] = b;
                    count = count + 2;
                end
                "S": begin
                    count      = $sscanf(fields, "%d %h %h %h", a, b, c, d);
                    s.cycles   = a;
                    s.stall    = b[0];
                    s.flush    = c[0];
                    s.flush_pc = d;
                    cycle_limit += int'(a);
                    steps.push_back(s);
                end
                "E": begin
                    count         = $sscanf(fields, "%h %h %h %h", a, b, c, d);
                    s.pc1         = a;
                    s.valid       = b[1:0];
                    s.redirect    = c[0];
                    s.redirect_pc = d;
                    cycle_limit += PAIR_CYCLES;
                    steps.push_back(s);
                end
                default: count = 0;
            endcase
            if (count != 4) begin
                end_with_failure($sformatf("Bad line in the test data file: %s", line));
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // Instruction cache model, one cycle latency
    //////////////////////////////////////////////////

    function automatic logic [31:0] read_word(input pc_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return NOP_WORD;
    endfunction

    always @(negedge clk) begin
        cache_pc    = o_fetch_pc;
        cache_stall = i_stall_icache;
    end

    initial begin
        i_inst1 = NOP_WORD;
        i_inst2 = NOP_WORD;
        forever begin
            @(posedge clk);
            #2;
            // Words held while the cache stalls
            if (cache_stall === 1'b0) begin
                latched_pc = cache_pc;
                i_inst1    = read_word(cache_pc);
                i_inst2    = read_word(cache_pc + 32'd4);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            end_with_failure($sformatf("Timeout after %0d cycles, expected IF2 pairs never came",
                cycle_count));
        end
    end

    //////////////////////////////////////////////////
    // Stimulus steps
    //////////////////////////////////////////////////

    // Stall or flush for some cycles, no pair may show meanwhile
    task automatic apply_inputs(input logic [31:0] cycles, input logic stall,
                                input logic flush, input pc_t flush_pc);
        i_stall_icache = stall;
        i_flush_br     = flush;
        i_flush_pc     = flush_pc;
        repeat (cycles) begin
            @(negedge clk);
            if (stall || flush) begin
                check_valid(2'b00, o_valid);
            end
            @(posedge clk);
            #2;
        end
        i_stall_icache = 1'b0;
        i_flush_br     = 1'b0;
    endtask

    task automatic expect_pair(input pc_t pc1, input logic [1:0] valid,
                               input logic redirect, input pc_t redirect_pc);
        @(negedge clk);
        while (o_valid == 2'b00) begin
            @(negedge clk);
        end
        // The pair in IF2 was fetched at the PC the cache last answered
        check_pc("o_fetch_pc of the cycle before", pc1, latched_pc);
        check_pc("o_pc1", pc1, o_pc1);
        check_pc("o_pc2", pc1 + 32'd4, o_pc2);
        check_valid(valid, o_valid);
        check_redirect(redirect, redirect_pc, o_redirect, o_redirect_pc);
        @(posedge clk);
        #2;
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rstn           = 1'b0;
        i_stall_icache = 1'b0;
        i_flush_br     = 1'b0;
        i_flush_pc     = '0;
        load_testdata();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rstn = 1'b1;
        foreach (steps[i]) begin
            if (steps[i].kind == "S") begin
                apply_inputs(steps[i].cycles, steps[i].stall, steps[i].flush,
                    steps[i].flush_pc);
            end else begin
                expect_pair(steps[i].pc1, steps[i].valid, steps[i].redirect,
                    steps[i].redirect_pc);
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- tb/fetch_testdata.txt
# M address word | S cycles(dec) stall flush flush_pc
# E pc1 valid_mask redirect redirect_pc | all other columns in hex

# Program image, every other word reads as a NOP
# JIRL in slot 2, BEQ, B back to the loop head, BL in slot 2
M 1C00000C 4C000020
M 1C000110 53FFF3FF
M 1C000200 58000822
M 1C00020C 5400F400

# Straight-line fetch from the reset PC
E 1C000000 3 0 00000000
E 1C000008 3 0 00000000
E 1C000010 3 0 00000000

# Cache stall, the held pair comes out first
S 3 1 0 00000000
E 1C000018 3 0 00000000
E 1C000020 3 0 00000000

# Branch flush into the loop
S 1 0 1 1C000100
E 1C000100 3 0 00000000
E 1C000108 3 0 00000000

# First pass, B misses the BTB
E 1C000110 1 1 1C000100
E 1C000100 3 0 00000000
E 1C000108 3 0 00000000

# Second pass predicted by the BTB
E 1C000110 1 0 00000000
E 1C000100 3 0 00000000

# Leave the loop, BEQ passes, BL in slot 2 redirects
S 1 0 1 1C000200
E 1C000200 3 0 00000000
E 1C000208 3 1 1C000300
E 1C000300 3 0 00000000

//--- sources.f
source/fetch_pkg.sv
source/inst_pkg.sv
source/fetch_if.sv
source/btb_predictor.sv
source/pc_gen.sv
source/if1_if2_reg.sv
source/predecoder.sv
source/fetch_top.sv
tb/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_tb -f sources.f -o fetch_sim \
    && ./obj_dir/fetch_sim | tee /dev/stderr | grep -F "RESULT: PASS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
